// ==== filelist.f ====
i2c_pkg.sv
i2c_ifs.sv
i2c_req_capture.sv
i2c_tick_gen.sv
i2c_bit_engine.sv
i2c_result_reg.sv
i2c_master_top.sv
tb_i2c_slave.sv
tb_i2c_master.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_i2c_master -f filelist.f -o sim_i2c_master &&
./obj_dir/sim_i2c_master | tee /dev/stderr | grep -q "Everything OK" &&
echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== tb_i2c_master.sv ====
/*
 * Testbench for the single-byte I2C master
 * Directed and LFSR-driven transactions against a behavioral target
 * with every result compared to a reference model
 */

`timescale 1ns/10ps

module tb_i2c_master;

    localparam int DIVIDE = 4;
    localparam logic [i2c_pkg::ADDR_W-1:0] SLAVE_ADDR = 7'h5a;
    localparam logic [31:0] LFSR_SEED = 32'hc69f_45c1;
    localparam int XFER_CYCLES = 20 * 4 * DIVIDE + 64;  // Longest transaction plus margin
    localparam int NUM_XFERS   = 48;                      // 47 transactions plus one quiet period
    localparam int TIMEOUT     = NUM_XFERS * XFER_CYCLES;

    logic                        clk;
    logic                        rst;
    logic                        start;
    logic [i2c_pkg::ADDR_W-1:0] addr;
    logic                        rw;
    logic [i2c_pkg::DATA_W-1:0] wdata;
    logic                        busy;
    logic                        done;
    logic [i2c_pkg::DATA_W-1:0] rx_data;
    logic                        addr_ack;
    logic                        data_ack;
    logic                        scl;
    logic                        dut_pull;
    logic                        slave_pull;
    logic                        sda_bus;

    logic [31:0]                 lfsr;
    logic [7:0]                  shadow_mem;  // Mirror of target storage
    logic [7:0]                  shadow_rx;   // Last expected rx_data
    logic [9:0]                  exp_q[$];    // {addr_ack, data_ack, rx_data}
    int                          issued;
    int                          done_cnt;
    int                          cycles;

    assign sda_bus = ~(dut_pull | slave_pull);    // Wired-AND with pull-up

    i2c_master_top #(
        .DIVIDE (DIVIDE)
    ) i_i2c_master_top (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .addr         (addr),
        .rw           (rw),
        .wdata        (wdata),
        .busy         (busy),
        .done         (done),
        .rx_data      (rx_data),
        .addr_ack     (addr_ack),
        .data_ack     (data_ack),
        .scl          (scl),
        .sda_pull_low (dut_pull),
        .sda_in       (sda_bus)
    );

    tb_i2c_slave #(
        .ADDR (SLAVE_ADDR)
    ) i_tb_i2c_slave (
        .scl          (scl),
        .sda          (sda_bus),
        .sda_pull_low (slave_pull)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    // Expected outcome and target mirror update
    function automatic logic [9:0] predict(input logic [6:0] a, input logic r,
                                           input logic [7:0] d);
        logic hit;
        hit = (a == SLAVE_ADDR);
        if (hit && !r)
            shadow_mem = d;             // Acked write stores the byte
        else if (hit && r)
            shadow_rx = shadow_mem;     // Acked read returns it
        return {hit, hit && !r, shadow_rx};
    endfunction

    task automatic check_value(input string name, input logic [31:0] want,
                               input logic [31:0] got);
        if (want !== got) begin
            $display("[ERROR] %0t ns %s expected %0h got %0h", $time, name, want, got);
            $display("Something failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic pulse_start(input logic [6:0] a, input logic r, input logic [7:0] d);
        @(posedge clk);
        start <= 1'b1;
        addr  <= a;
        rw    <= r;
        wdata <= d;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic issue_xfer(input logic [6:0] a, input logic r, input logic [7:0] d);
        exp_q.push_back(predict(a, r, d));
        issued++;
        pulse_start(a, r, d);
    endtask

    task automatic wait_results();
        while (done_cnt < issued)
            @(posedge clk);
    endtask

    task automatic run_xfer(input logic [6:0] a, input logic r, input logic [7:0] d);
        issue_xfer(a, r, d);
        wait_results();
    endtask

    // Compare at negedge when outputs are settled
    initial begin : compare_results
        logic [9:0] want;
        forever begin
            @(negedge clk);
            if (done === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("Done pulse at %0t ns with no request pending", $time);
                    $display("Something failed");
                    $fatal(1, "Stray done pulse");
                end else begin
                    want = exp_q.pop_front();
                    check_value("addr_ack", 32'(want[9]), 32'(addr_ack));
                    check_value("data_ack", 32'(want[8]), 32'(data_ack));
                    check_value("rx_data", 32'(want[7:0]), 32'(rx_data));
                    done_cnt++;
                end
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, transaction never completed", TIMEOUT);
        $display("Something failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin : stimulus
        logic [31:0] rnd;
        logic        use_slave;
        logic [6:0]  cand;
        logic        dir;
        logic [7:0]  data_v;
        rst        = 1'b1;
        start      = 1'b0;
        addr       = '0;
        rw         = 1'b0;
        wdata      = '0;
        lfsr       = LFSR_SEED;
        shadow_mem = 8'h00;
        shadow_rx  = 8'h00;
        issued     = 0;
        done_cnt   = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);                             // Idle bus after reset
        check_value("busy", 32'd0, 32'(busy));
        check_value("done", 32'd0, 32'(done));
        check_value("scl", 32'd1, 32'(scl));
        check_value("sda_pull_low", 32'd0, 32'(dut_pull));

        run_xfer(SLAVE_ADDR, 1'b0, 8'h96);          // Write then read back
        run_xfer(SLAVE_ADDR, 1'b1, 8'h00);

        run_xfer(7'h21, 1'b0, 8'h3c);               // Nobody answers
        run_xfer(7'h21, 1'b1, 8'h00);
        run_xfer(SLAVE_ADDR, 1'b1, 8'h00);          // Storage still 96

        issue_xfer(SLAVE_ADDR, 1'b0, 8'ha5);        // Second start lands while busy
        repeat (5) @(negedge clk);
        check_value("busy", 32'd1, 32'(busy));
        pulse_start(SLAVE_ADDR, 1'b0, 8'h5a);
        wait_results();
        repeat (XFER_CYCLES) @(posedge clk);        // No second done may follow
        check_value("busy", 32'd0, 32'(busy));
        run_xfer(SLAVE_ADDR, 1'b1, 8'h00);          // Expect a5 and not 5a

        for (int n = 0; n < 40; n++) begin
            rnd       = take_bits(1);
            use_slave = rnd[0];
            rnd       = take_bits(7);
            cand      = rnd[6:0];
            rnd       = take_bits(1);
            dir       = rnd[0];
            rnd       = take_bits(8);
            data_v    = rnd[7:0];
            run_xfer(use_slave ? SLAVE_ADDR : cand, dir, data_v);
        end

        repeat (4) @(posedge clk);
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== tb_i2c_slave.sv ====
/*
 * Behavioral I2C target for the master testbench
 * One fixed address and one storage byte, ACKs writes and answers reads
 */

`timescale 1ns/10ps

module tb_i2c_slave #(
    parameter logic [6:0] ADDR = 7'h5a      // Address this target answers
) (
    input  logic scl,
    input  logic sda,                       // Resolved bus
    output logic sda_pull_low               // 1 pulls the bus low
);

    logic [7:0] storage;
    logic [7:0] shift;
    logic       hit;

    // START is SDA falling while SCL is high
    task automatic wait_start();
        logic seen;
        seen = 1'b0;
        while (!seen) begin
            @(negedge sda);
            seen = (scl === 1'b1);
        end
    endtask

    // Eight bits, MSB first, sampled while SCL is high
    task automatic take_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            @(posedge scl);
            b = {b[6:0], sda};
        end
    endtask

    // Bits change on SCL falling, bus released for the master NACK
    task automatic send_byte(input logic [7:0] b);
        for (int i = 7; i >= 0; i--) begin
            sda_pull_low = ~b[i];
            @(negedge scl);
        end
        sda_pull_low = 1'b0;
    endtask

    initial begin
        sda_pull_low = 1'b0;
        storage      = 8'h00;
        forever begin
            wait_start();
            take_byte(shift);               // Address plus R/W
            hit = (shift[7:1] == ADDR);
            @(negedge scl);
            sda_pull_low = hit;             // Address ACK
            @(negedge scl);
            if (hit && shift[0]) begin
                send_byte(storage);         // First bit goes out right away
            end else begin
                sda_pull_low = 1'b0;
                if (hit) begin
                    take_byte(shift);       // Write byte
                    @(negedge scl);
                    sda_pull_low = 1'b1;    // Data ACK
                    @(negedge scl);
                    sda_pull_low = 1'b0;
                    storage = shift;
                end
            end
        end
    end

endmodule

// ==== i2c_master_top.sv ====
/*
 * Single-byte I2C master
 * Strobe request in, one bus transaction, results out with a done pulse
 */

`timescale 1ns/10ps

module i2c_master_top #(
    parameter int DIVIDE = 4                        // clk cycles per quarter bit
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  logic [i2c_pkg::ADDR_W-1:0] addr,
    input  logic                        rw,
    input  logic [i2c_pkg::DATA_W-1:0] wdata,
    output logic                        busy,
    output logic                        done,
    output logic [i2c_pkg::DATA_W-1:0] rx_data,
    output logic                        addr_ack,
    output logic                        data_ack,
    output logic                        scl,
    output logic                        sda_pull_low,
    input  logic                        sda_in
);

    i2c_req_if req_bus ();
    i2c_rsp_if rsp_bus ();

    logic tick;
    logic run;

    i2c_req_capture i_i2c_req_capture (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .addr      (addr),
        .rw        (rw),
        .wdata     (wdata),
        .xfer_done (rsp_bus.done),                  // Busy drops with top-level done
        .busy      (busy),
        .req       (req_bus.source)
    );

    i2c_tick_gen #(
        .DIVIDE (DIVIDE)
    ) i_i2c_tick_gen (
        .clk  (clk),
        .rst  (rst),
        .run  (run),
        .tick (tick)
    );

    i2c_bit_engine i_i2c_bit_engine (
        .clk          (clk),
        .rst          (rst),
        .tick         (tick),
        .run          (run),
        .req          (req_bus.sink),
        .rsp          (rsp_bus.source),
        .scl          (scl),
        .sda_pull_low (sda_pull_low),
        .sda_in       (sda_in)
    );

    i2c_result_reg i_i2c_result_reg (
        .clk      (clk),
        .rst      (rst),
        .rsp      (rsp_bus.sink),
        .done     (done),
        .rx_data  (rx_data),
        .addr_ack (addr_ack),
        .data_ack (data_ack)
    );

endmodule

// ==== i2c_result_reg.sv ====
/*
 * I2C result register
 * Latches received byte and ACK flags on completion, pulses done
 */

`timescale 1ns/10ps

module i2c_result_reg (
    input  logic                        clk,
    input  logic                        rst,
    i2c_rsp_if.sink                     rsp,
    output logic                        done,
    output logic [i2c_pkg::DATA_W-1:0] rx_data,
    output logic                        addr_ack,
    output logic                        data_ack
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done     <= 1'b0;
            rx_data  <= '0;
            addr_ack <= 1'b0;
            data_ack <= 1'b0;
        end else begin
            done <= rsp.done;               // One cycle behind the engine
            if (rsp.done) begin
                rx_data  <= rsp.rx_data;    // Engine keeps old byte on writes
                addr_ack <= rsp.addr_ack;
                data_ack <= rsp.data_ack;
            end
        end
    end

endmodule

// ==== i2c_bit_engine.sv ====
/*
 * I2C bit engine
 * Runs one transaction per request, START to STOP, with SCL and SDA control
 * Four ticks per bit, SCL low in quarters 0-1 and high in 2-3
 */

`timescale 1ns/10ps

module i2c_bit_engine (
    input  logic       clk,
    input  logic       rst,
    input  logic       tick,            // Quarter-bit strobe
    output logic       run,             // High from request until done
    i2c_req_if.sink    req,
    i2c_rsp_if.source  rsp,
    output logic       scl,             // Push-pull clock
    output logic       sda_pull_low,    // Open-drain data, 1 pulls low
    input  logic       sda_in           // Resolved bus data
);

    i2c_pkg::i2c_state_e         state;
    logic [1:0]                  qtr;        // Quarter within bit period
    logic [2:0]                  bit_cnt;    // Bits left in byte
    logic [i2c_pkg::DATA_W-1:0]  tx_sh;      // Outgoing shifter
    logic [i2c_pkg::DATA_W-1:0]  rx_sh;      // Incoming shifter
    logic [i2c_pkg::DATA_W-1:0]  wdata_q;
    i2c_pkg::i2c_dir_e           dir_q;
    logic                        addr_ack_q;
    logic                        data_ack_q;
    logic                        done_q;
    logic                        sda_pull_nxt;
    logic                        sample_pt;  // Start of quarter 2
    logic                        period_end; // End of quarter 3
    logic                        accept;

    assign run        = (state != i2c_pkg::ST_IDLE);
    assign accept     = (state == i2c_pkg::ST_IDLE) && req.valid;
    assign sample_pt  = tick && (qtr == 2'd1);
    assign period_end = tick && (qtr == 2'd3);

    // SCL follows the quarter counter, held high around START
    assign scl = (state == i2c_pkg::ST_IDLE || state == i2c_pkg::ST_START) ? 1'b1 : qtr[1];

    // SDA target, registered so it moves one clk after SCL
    always_comb begin
        case (state)
            i2c_pkg::ST_START: sda_pull_nxt = qtr[1];             // Fall with SCL high
            i2c_pkg::ST_ADDR,
            i2c_pkg::ST_WDATA: sda_pull_nxt = ~tx_sh[i2c_pkg::DATA_W-1];
            i2c_pkg::ST_STOP:  sda_pull_nxt = (qtr != 2'd3);      // Rise in last quarter
            default:           sda_pull_nxt = 1'b0;               // Released, target drives
        endcase
    end

    // Transaction FSM and control flags
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= i2c_pkg::ST_IDLE;
            qtr          <= 2'd0;
            bit_cnt      <= 3'd0;
            addr_ack_q   <= 1'b0;
            data_ack_q   <= 1'b0;
            done_q       <= 1'b0;
            sda_pull_low <= 1'b0;
            rx_sh        <= '0;
        end else begin
            done_q       <= 1'b0;
            sda_pull_low <= sda_pull_nxt;
            if (state == i2c_pkg::ST_IDLE) begin
                qtr <= 2'd0;
                if (req.valid) begin
                    state      <= i2c_pkg::ST_START;
                    addr_ack_q <= 1'b0;
                    data_ack_q <= 1'b0;
                end
            end else if (tick) begin
                qtr <= qtr + 2'd1;
                if (sample_pt) begin
                    case (state)
                        i2c_pkg::ST_ADDR_ACK:  addr_ack_q <= ~sda_in;  // ACK is low
                        i2c_pkg::ST_WDATA_ACK: data_ack_q <= ~sda_in;
                        i2c_pkg::ST_RDATA:     rx_sh <= {rx_sh[i2c_pkg::DATA_W-2:0], sda_in};
                        default: ;
                    endcase
                end
                if (period_end) begin
                    case (state)
                        i2c_pkg::ST_START: begin
                            state   <= i2c_pkg::ST_ADDR;
                            bit_cnt <= 3'd7;
                        end
                        i2c_pkg::ST_ADDR, i2c_pkg::ST_WDATA, i2c_pkg::ST_RDATA: begin
                            bit_cnt <= bit_cnt - 3'd1;
                            if (bit_cnt == 3'd0) begin
                                case (state)
                                    i2c_pkg::ST_ADDR:  state <= i2c_pkg::ST_ADDR_ACK;
                                    i2c_pkg::ST_WDATA: state <= i2c_pkg::ST_WDATA_ACK;
                                    default:           state <= i2c_pkg::ST_MNACK;
                                endcase
                            end
                        end
                        i2c_pkg::ST_ADDR_ACK: begin
                            bit_cnt <= 3'd7;
                            if (!addr_ack_q)
                                state <= i2c_pkg::ST_STOP;      // Address NACK
                            else if (dir_q == i2c_pkg::DIR_WRITE)
                                state <= i2c_pkg::ST_WDATA;
                            else
                                state <= i2c_pkg::ST_RDATA;
                        end
                        i2c_pkg::ST_WDATA_ACK,
                        i2c_pkg::ST_MNACK: state <= i2c_pkg::ST_STOP;
                        default: begin                          // ST_STOP
                            state  <= i2c_pkg::ST_IDLE;
                            done_q <= 1'b1;
                        end
                    endcase
                end
            end
        end
    end

    // Request payload and outgoing shifter
    always_ff @(posedge clk) begin
        if (accept) begin
            tx_sh   <= {req.addr, req.dir};     // Address byte with R/W
            wdata_q <= req.wdata;
            dir_q   <= req.dir;
        end else if (period_end) begin
            if (state == i2c_pkg::ST_ADDR_ACK)
                tx_sh <= wdata_q;               // Ready for data phase
            else if (state == i2c_pkg::ST_ADDR || state == i2c_pkg::ST_WDATA)
                tx_sh <= {tx_sh[i2c_pkg::DATA_W-2:0], 1'b0};
        end
    end

    assign rsp.done     = done_q;
    assign rsp.rx_data  = rx_sh;    // Unchanged unless a read ran
    assign rsp.addr_ack = addr_ack_q;
    assign rsp.data_ack = data_ack_q;

endmodule

// ==== i2c_tick_gen.sv ====
/*
 * Quarter-bit tick generator
 * One tick per DIVIDE clk cycles while a transaction runs
 */

`timescale 1ns/10ps

module i2c_tick_gen #(
    parameter int DIVIDE = 4            // clk cycles per quarter SCL period
) (
    input  logic clk,
    input  logic rst,
    input  logic run,                   // Engine active
    output logic tick
);

    localparam int CNT_W = (DIVIDE > 1) ? $clog2(DIVIDE) : 1;

    logic [CNT_W-1:0] cnt;

    assign tick = run && (cnt == CNT_W'(DIVIDE - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            cnt <= '0;
        else if (!run || tick)
            cnt <= '0;                  // Held at zero when idle, aligns first quarter
        else
            cnt <= cnt + 1'b1;
    end

endmodule

// ==== i2c_req_capture.sv ====
/*
 * I2C request capture
 * Takes a start strobe when idle, holds the request and keeps busy
 */

`timescale 1ns/10ps

module i2c_req_capture (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,     // Request strobe
    input  logic [i2c_pkg::ADDR_W-1:0] addr,
    input  logic                        rw,        // 0 write, 1 read
    input  logic [i2c_pkg::DATA_W-1:0] wdata,
    input  logic                        xfer_done, // Transaction finished
    output logic                        busy,
    i2c_req_if.source                   req
);

    logic take;     // Accepted request this cycle

    assign take = start && !busy;   // Starts while busy are dropped

    // Control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            req.valid <= 1'b0;
        end else begin
            req.valid <= take;          // Pulses with busy rising
            if (take)
                busy <= 1'b1;
            else if (xfer_done)
                busy <= 1'b0;           // Drops with top-level done
        end
    end

    // Request payload, held for the engine
    always_ff @(posedge clk) begin
        if (take) begin
            req.addr  <= addr;
            req.dir   <= i2c_pkg::i2c_dir_e'(rw);
            req.wdata <= wdata;
        end
    end

endmodule

// ==== i2c_ifs.sv ====
/*
 * Internal request and response bundles of the I2C master
 * Request runs capture to engine, response runs engine to result register
 */

`timescale 1ns/10ps

interface i2c_req_if;

    logic                        valid;   // One-cycle request pulse
    logic [i2c_pkg::ADDR_W-1:0] addr;    // Target address
    i2c_pkg::i2c_dir_e           dir;     // Write or read
    logic [i2c_pkg::DATA_W-1:0] wdata;   // Byte to write

    modport source (output valid, addr, dir, wdata);
    modport sink   (input  valid, addr, dir, wdata);

endinterface

interface i2c_rsp_if;

    logic                        done;     // One-cycle completion pulse
    logic [i2c_pkg::DATA_W-1:0] rx_data;  // Received byte
    logic                        addr_ack; // Target acked address
    logic                        data_ack; // Target acked write byte

    modport source (output done, rx_data, addr_ack, data_ack);
    modport sink   (input  done, rx_data, addr_ack, data_ack);

endinterface

// ==== i2c_pkg.sv ====
/*
 * I2C master shared definitions
 * Bus widths, transfer direction and engine state encodings
 */

package i2c_pkg;

    parameter int ADDR_W = 7;       // 7-bit target address
    parameter int DATA_W = 8;       // One data byte

    // Matches the R/W bit sent after the address
    typedef enum logic {
        DIR_WRITE = 1'b0,
        DIR_READ  = 1'b1
    } i2c_dir_e;

    // Bit engine states, one bus bit period each
    typedef enum logic [3:0] {
        ST_IDLE,        // Bus free, SCL and SDA high
        ST_START,       // SDA falls while SCL high
        ST_ADDR,        // Address plus R/W, MSB first
        ST_ADDR_ACK,    // Target ACK after address
        ST_WDATA,       // Write byte, MSB first
        ST_WDATA_ACK,   // Target ACK after write byte
        ST_RDATA,       // Read byte from target
        ST_MNACK,       // Master NACK ends the read
        ST_STOP         // SDA rises while SCL high
    } i2c_state_e;

endpackage
